// ==== Bender.yml ====
package:
  name: cpu

sources:
  - design/cpu_pkg.sv
  - design/alu.sv
  - design/register_file.sv
  - design/control.sv
  - design/hazard_unit.sv
  - design/cpu.sv
  - design/data_memory.sv
  - design/cpu_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_cpu.sv

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  logic [cpu_pkg::word_size-1:0] a,
	input  logic [cpu_pkg::word_size-1:0] b,
	input  cpu_pkg::alu_op_t              op,
	output logic [cpu_pkg::word_size-1:0] result
);
	import cpu_pkg::*;

	always_comb begin
		case (op)
			alu_add:
				result = a + b;
			alu_sub:
				result = a - b;
			alu_and:
				result = a & b;
			alu_or:
				result = a | b;
			// low byte of the immediate into the upper byte
			alu_lhi:
				result = {b[7:0], 8'h00};
			// wwd value
			alu_pass_a:
				result = a;
			default:
				result = '0;
		endcase
	end

endmodule

// ==== design/control.sv ====
`timescale 1ns/1ps

module control (
	input  cpu_pkg::instr_t instr,
	output cpu_pkg::ctrl_t  ctrl
);
	import cpu_pkg::*;

	function automatic ctrl_t rtype_alu(input alu_op_t op);
		ctrl_t c;
		c = '0;
		c.alu_op = op;
		c.dest_is_rd = 1'b1;
		c.reg_write = 1'b1;
		return c;
	endfunction

	function automatic ctrl_t itype_alu(input alu_op_t op);
		ctrl_t c;
		c = '0;
		c.alu_op = op;
		c.use_imm = 1'b1;
		c.reg_write = 1'b1;
		return c;
	endfunction

	always_comb begin
		ctrl = '0;
		case (instr.r_fmt.opcode)
			op_rtype: begin
				case (instr.r_fmt.func)
					fn_add: ctrl = rtype_alu(alu_add);
					fn_sub: ctrl = rtype_alu(alu_sub);
					fn_and: ctrl = rtype_alu(alu_and);
					fn_orr: ctrl = rtype_alu(alu_or);
					fn_wwd: begin
						ctrl.alu_op = alu_pass_a;
						ctrl.is_wwd = 1'b1;
					end
					fn_hlt: ctrl.is_hlt = 1'b1;
					default: ctrl = '0;
				endcase
			end
			op_adi: ctrl = itype_alu(alu_add);
			op_ori: ctrl = itype_alu(alu_or);
			op_lhi: ctrl = itype_alu(alu_lhi);
			op_lwd: begin
				ctrl = itype_alu(alu_add);
				ctrl.mem_read = 1'b1;
				ctrl.mem_to_reg = 1'b1;
			end
			// address is rs + imm, data comes from rt
			op_swd: begin
				ctrl = itype_alu(alu_add);
				ctrl.reg_write = 1'b0;
				ctrl.mem_write = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

	always_comb begin
		assert final (!(ctrl.mem_read && ctrl.mem_write))
			else $error("control: load and store decoded together");
	end

endmodule

// ==== design/cpu.sv ====
`timescale 1ns/1ps

module cpu (
	input  logic                          Clk,
	input  logic                          rst,
	output logic                          read_inst,
	output logic [cpu_pkg::word_size-1:0] inst_addr,
	input  logic [cpu_pkg::word_size-1:0] inst_data,
	output cpu_pkg::mem_req_t             mem_req,
	input  logic [cpu_pkg::word_size-1:0] read_data,
	output logic [cpu_pkg::word_size-1:0] num_inst,
	output logic [cpu_pkg::word_size-1:0] output_port,
	output logic                          is_halted
);
	import cpu_pkg::*;

	logic [word_size-1:0] pc;
	logic                 fetch_en;
	logic                 halting;

	instr_t               if_id_instr;
	ctrl_t                id_ctrl;
	logic [word_size-1:0] id_rs_data;
	logic [word_size-1:0] id_rt_data;
	logic [word_size-1:0] id_imm;
	logic                 id_uses_rt;
	logic                 stall;

	ctrl_t                ex_ctrl;
	logic [word_size-1:0] ex_rs_data;
	logic [word_size-1:0] ex_rt_data;
	logic [word_size-1:0] ex_imm;
	logic [1:0]           ex_rs;
	logic [1:0]           ex_rt;
	logic [1:0]           ex_rd;
	logic [1:0]           ex_dest;
	fwd_sel_t             fwd_a;
	fwd_sel_t             fwd_b;
	logic [word_size-1:0] ex_a;
	logic [word_size-1:0] ex_b_reg;
	logic [word_size-1:0] ex_result;

	ctrl_t                mem_ctrl;
	logic [word_size-1:0] mem_result;
	logic [word_size-1:0] mem_store_data;
	logic [1:0]           mem_dest;

	ctrl_t                wb_ctrl;
	logic [word_size-1:0] wb_result;
	logic [word_size-1:0] wb_load_data;
	logic [word_size-1:0] wb_value;
	logic [1:0]           wb_dest;

	// fetch, stops for good once hlt reaches decode
	assign read_inst = fetch_en && !halting && !id_ctrl.is_hlt;
	assign inst_addr = pc;

	always_ff @(posedge Clk) begin
		if (rst) begin
			pc <= '0;
			fetch_en <= 1'b0;
			halting <= 1'b0;
			if_id_instr <= '0;
		end else begin
			fetch_en <= 1'b1;
			halting <= halting || id_ctrl.is_hlt;
			if (!stall) begin
				if_id_instr <= read_inst ? instr_t'(inst_data) : instr_t'('0);
				if (read_inst)
					pc <= pc + 1'b1;
			end
		end
	end

	control u_control (
		.instr(if_id_instr),
		.ctrl (id_ctrl)
	);

	register_file u_register_file (
		.Clk       (Clk),
		.rst       (rst),
		.rs        (if_id_instr.r_fmt.rs),
		.rt        (if_id_instr.r_fmt.rt),
		.rd        (wb_dest),
		.write_data(wb_value),
		.reg_write (wb_ctrl.reg_write),
		.rs_data   (id_rs_data),
		.rt_data   (id_rt_data)
	);

	assign id_imm = {{8{if_id_instr.i_fmt.imm[7]}}, if_id_instr.i_fmt.imm};
	// register-format alu ops and stores read rt
	assign id_uses_rt = id_ctrl.mem_write || (id_ctrl.reg_write && !id_ctrl.use_imm);

	hazard_unit u_hazard_unit (
		.Clk       (Clk),
		.rst       (rst),
		.ex_rs     (ex_rs),
		.ex_rt     (ex_rt),
		.id_rs     (if_id_instr.r_fmt.rs),
		.id_rt     (if_id_instr.r_fmt.rt),
		.id_uses_rt(id_uses_rt),
		.mem_dest  (mem_dest),
		.wb_dest   (wb_dest),
		.mem_ctrl  (mem_ctrl),
		.wb_ctrl   (wb_ctrl),
		.ex_ctrl   (ex_ctrl),
		.ex_dest   (ex_dest),
		.fwd_a     (fwd_a),
		.fwd_b     (fwd_b),
		.stall     (stall)
	);

	always_ff @(posedge Clk) begin
		if (rst) begin
			ex_ctrl <= '0;
			mem_ctrl <= '0;
			wb_ctrl <= '0;
		end else begin
			ex_ctrl <= stall ? ctrl_t'('0) : id_ctrl;
			mem_ctrl <= ex_ctrl;
			wb_ctrl <= mem_ctrl;
		end
	end

	always_ff @(posedge Clk) begin
		ex_rs_data <= id_rs_data;
		ex_rt_data <= id_rt_data;
		ex_imm <= id_imm;
		ex_rs <= if_id_instr.r_fmt.rs;
		ex_rt <= if_id_instr.r_fmt.rt;
		ex_rd <= if_id_instr.r_fmt.rd;
		mem_result <= ex_result;
		mem_store_data <= ex_b_reg;
		mem_dest <= ex_dest;
		wb_result <= mem_result;
		wb_load_data <= read_data;
		wb_dest <= mem_dest;
	end

	// execute
	assign ex_dest = ex_ctrl.dest_is_rd ? ex_rd : ex_rt;
	assign ex_a = (fwd_a == fwd_mem) ? mem_result :
		(fwd_a == fwd_wb) ? wb_value : ex_rs_data;
	assign ex_b_reg = (fwd_b == fwd_mem) ? mem_result :
		(fwd_b == fwd_wb) ? wb_value : ex_rt_data;

	alu u_alu (
		.a     (ex_a),
		.b     (ex_ctrl.use_imm ? ex_imm : ex_b_reg),
		.op    (ex_ctrl.alu_op),
		.result(ex_result)
	);

	assign mem_req.read = mem_ctrl.mem_read;
	assign mem_req.write = mem_ctrl.mem_write;
	assign mem_req.addr = mem_result;
	assign mem_req.wdata = mem_store_data;

	assign wb_value = wb_ctrl.mem_to_reg ? wb_load_data : wb_result;

	// retire, any non-bubble leaving writeback
	always_ff @(posedge Clk) begin
		if (rst) begin
			num_inst <= '0;
			output_port <= '0;
			is_halted <= 1'b0;
		end else if (wb_ctrl != '0) begin
			num_inst <= num_inst + 1'b1;
			if (wb_ctrl.is_wwd)
				output_port <= wb_result;
			if (wb_ctrl.is_hlt)
				is_halted <= 1'b1;
		end
	end

	assert property (@(posedge Clk) disable iff (rst) is_halted |-> !read_inst)
		else $error("cpu: fetch active after halt");

endmodule

// ==== design/cpu_pkg.sv ====
package cpu_pkg;

	localparam int word_size = 16;

	typedef enum logic [3:0] {
		op_adi   = 4'd4,
		op_ori   = 4'd5,
		op_lhi   = 4'd6,
		op_lwd   = 4'd7,
		op_swd   = 4'd8,
		op_rtype = 4'd15
	} opcode_t;

	typedef enum logic [5:0] {
		fn_add = 6'd0,
		fn_sub = 6'd1,
		fn_and = 6'd2,
		fn_orr = 6'd3,
		fn_wwd = 6'd28,
		fn_hlt = 6'd29
	} func_t;

	typedef enum logic [2:0] {
		alu_add    = 3'd0,
		alu_sub    = 3'd1,
		alu_and    = 3'd2,
		alu_or     = 3'd3,
		alu_lhi    = 3'd4,
		alu_pass_a = 3'd5
	} alu_op_t;

	// same 16-bit word, register or immediate format
	typedef union packed {
		struct packed {
			opcode_t    opcode;
			logic [1:0] rs;
			logic [1:0] rt;
			logic [1:0] rd;
			func_t      func;
		} r_fmt;
		struct packed {
			opcode_t    opcode;
			logic [1:0] rs;
			logic [1:0] rt;
			logic [7:0] imm;
		} i_fmt;
	} instr_t;

	// all zero is a bubble
	typedef struct packed {
		alu_op_t alu_op;
		logic    use_imm;
		logic    dest_is_rd;
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    mem_to_reg;
		logic    is_wwd;
		logic    is_hlt;
	} ctrl_t;

	typedef struct packed {
		logic                 read;
		logic                 write;
		logic [word_size-1:0] addr;
		logic [word_size-1:0] wdata;
	} mem_req_t;

	typedef enum logic [1:0] {
		fwd_none = 2'd0,
		fwd_mem  = 2'd1,
		fwd_wb   = 2'd2
	} fwd_sel_t;

endpackage

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
	parameter int data_depth = 256
) (
	input  logic                          Clk,
	input  logic                          rst,
	output logic                          read_inst,
	output logic [cpu_pkg::word_size-1:0] inst_addr,
	input  logic [cpu_pkg::word_size-1:0] inst_data,
	output logic [cpu_pkg::word_size-1:0] num_inst,
	output logic [cpu_pkg::word_size-1:0] output_port,
	output logic                          is_halted
);
	import cpu_pkg::*;

	mem_req_t             mem_req;
	logic [word_size-1:0] read_data;

	cpu u_cpu (
		.Clk        (Clk),
		.rst        (rst),
		.read_inst  (read_inst),
		.inst_addr  (inst_addr),
		.inst_data  (inst_data),
		.mem_req    (mem_req),
		.read_data  (read_data),
		.num_inst   (num_inst),
		.output_port(output_port),
		.is_halted  (is_halted)
	);

	data_memory #(
		.data_depth(data_depth)
	) u_data_memory (
		.Clk      (Clk),
		.mem_req  (mem_req),
		.read_data(read_data)
	);

endmodule

// ==== design/data_memory.sv ====
`timescale 1ns/1ps

module data_memory #(
	parameter int data_depth = 256
) (
	input  logic                          Clk,
	input  cpu_pkg::mem_req_t             mem_req,
	output logic [cpu_pkg::word_size-1:0] read_data
);
	import cpu_pkg::*;

	localparam int addr_bits = $clog2(data_depth);

	logic [word_size-1:0] mem [data_depth];
	logic [addr_bits-1:0] index;

	// word address wraps at the array size
	assign index = addr_bits'(mem_req.addr % data_depth);

	assign read_data = mem[index];

	always_ff @(posedge Clk) begin
		if (mem_req.write)
			mem[index] <= mem_req.wdata;
	end

endmodule

// ==== design/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
	input  logic               Clk,
	input  logic               rst,
	input  logic [1:0]         ex_rs,
	input  logic [1:0]         ex_rt,
	input  logic [1:0]         id_rs,
	input  logic [1:0]         id_rt,
	input  logic               id_uses_rt,
	input  logic [1:0]         mem_dest,
	input  logic [1:0]         wb_dest,
	input  cpu_pkg::ctrl_t     mem_ctrl,
	input  cpu_pkg::ctrl_t     wb_ctrl,
	input  cpu_pkg::ctrl_t     ex_ctrl,
	input  logic [1:0]         ex_dest,
	output cpu_pkg::fwd_sel_t  fwd_a,
	output cpu_pkg::fwd_sel_t  fwd_b,
	output logic               stall
);
	import cpu_pkg::*;

	// youngest producer wins
	function automatic fwd_sel_t pick(input logic [1:0] src, input ctrl_t m_ctrl,
			input logic [1:0] m_dest, input ctrl_t w_ctrl, input logic [1:0] w_dest);
		if (m_ctrl.reg_write && m_dest == src)
			return fwd_mem;
		if (w_ctrl.reg_write && w_dest == src)
			return fwd_wb;
		return fwd_none;
	endfunction

	assign fwd_a = pick(ex_rs, mem_ctrl, mem_dest, wb_ctrl, wb_dest);
	assign fwd_b = pick(ex_rt, mem_ctrl, mem_dest, wb_ctrl, wb_dest);

	// rs compared always, an extra stall on lhi or hlt is harmless
	assign stall = ex_ctrl.mem_read &&
		(ex_dest == id_rs || (id_uses_rt && ex_dest == id_rt));

	// the bubble behind a stall clears the load from execute
	assert property (@(posedge Clk) disable iff (rst) stall |=> !stall)
		else $error("hazard_unit: stall held for a second cycle");

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input  logic                          Clk,
	input  logic                          rst,
	input  logic [1:0]                    rs,
	input  logic [1:0]                    rt,
	input  logic [1:0]                    rd,
	input  logic [cpu_pkg::word_size-1:0] write_data,
	input  logic                          reg_write,
	output logic [cpu_pkg::word_size-1:0] rs_data,
	output logic [cpu_pkg::word_size-1:0] rt_data
);
	import cpu_pkg::*;

	logic [word_size-1:0] regs [4];

	always_ff @(posedge Clk) begin
		if (rst) begin
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
		end else if (reg_write) begin
			regs[rd] <= write_data;
		end
	end

	// write-through, covers writeback to decode
	assign rs_data = (reg_write && rd == rs) ? write_data : regs[rs];
	assign rt_data = (reg_write && rd == rt) ? write_data : regs[rt];

endmodule

// ==== sources.f ====
+incdir+tests
design/cpu_pkg.sv
design/alu.sv
design/register_file.sv
design/control.sv
design/hazard_unit.sv
design/cpu.sv
design/data_memory.sv
design/cpu_top.sv
tests/tb_cpu.sv

// ==== tests/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int num_tests = 6;
localparam int max_words = 16;

string       test_name [num_tests];
logic [15:0] programs  [num_tests][max_words];
int          prog_len  [num_tests];
logic [15:0] exp_out   [num_tests];
int          exp_num   [num_tests];

// rd = rs op rt
function automatic logic [15:0] r_word(input func_t fn, input logic [1:0] rs,
		input logic [1:0] rt, input logic [1:0] rd);
	return {op_rtype, rs, rt, rd, fn};
endfunction

function automatic logic [15:0] i_word(input opcode_t op, input logic [1:0] rs,
		input logic [1:0] rt, input logic [7:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic logic [15:0] sext8(input logic [7:0] imm);
	return {{8{imm[7]}}, imm};
endfunction

task automatic emit(input int t, input logic [15:0] word);
	programs[t][prog_len[t]] = word;
	prog_len[t]++;
endtask

// store then reload through a negative offset, same word 20
task automatic load_program(input int t, input bit spaced);
	emit(t, i_word(op_lhi, 2'd0, 2'd1, 8'h3c));
	emit(t, i_word(op_ori, 2'd1, 2'd1, 8'h55));
	emit(t, i_word(op_adi, 2'd0, 2'd2, 8'h10));
	emit(t, i_word(op_swd, 2'd2, 2'd1, 8'h04));
	emit(t, i_word(op_adi, 2'd2, 2'd2, 8'h08));
	emit(t, i_word(op_lwd, 2'd2, 2'd3, 8'hfc));
	if (spaced)
		emit(t, i_word(op_ori, 2'd2, 2'd2, 8'h00));
	emit(t, r_word(fn_add, 2'd3, 2'd1, 2'd0));
	emit(t, r_word(fn_wwd, 2'd0, 2'd0, 2'd0));
	emit(t, r_word(fn_hlt, 2'd0, 2'd0, 2'd0));
endtask

task automatic build_table();
	int          t;
	int          i;
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] c;
	logic [15:0] rng;
	logic [7:0]  imm [3];

	for (t = 0; t < num_tests; t++) begin
		prog_len[t] = 0;
		for (i = 0; i < max_words; i++)
			programs[t][i] = '0;
	end

	// dependent chain, every operand forwarded
	test_name[0] = "alu_forward";
	emit(0, i_word(op_adi, 2'd0, 2'd1, 8'd12));
	emit(0, i_word(op_adi, 2'd0, 2'd2, 8'd10));
	emit(0, r_word(fn_add, 2'd1, 2'd2, 2'd3));
	emit(0, r_word(fn_sub, 2'd3, 2'd2, 2'd1));
	emit(0, r_word(fn_and, 2'd1, 2'd3, 2'd2));
	emit(0, r_word(fn_orr, 2'd2, 2'd1, 2'd3));
	emit(0, r_word(fn_sub, 2'd2, 2'd3, 2'd0));
	emit(0, r_word(fn_wwd, 2'd0, 2'd0, 2'd0));
	emit(0, r_word(fn_hlt, 2'd0, 2'd0, 2'd0));
	a = 16'd12;
	b = 16'd10;
	c = a + b;
	a = c - b;
	b = a & c;
	c = b | a;
	exp_out[0] = b - c;
	exp_num[0] = prog_len[0];

	test_name[1] = "imm_extend";
	rng = 16'd43313;
	for (i = 0; i < 3; i++) begin
		rng = xorshift16(rng);
		imm[i] = rng[7:0];
	end
	emit(1, i_word(op_adi, 2'd0, 2'd1, imm[0]));
	emit(1, i_word(op_adi, 2'd1, 2'd1, imm[1]));
	emit(1, i_word(op_adi, 2'd1, 2'd1, imm[2]));
	emit(1, i_word(op_ori, 2'd0, 2'd3, 8'h85));
	emit(1, i_word(op_lhi, 2'd0, 2'd2, 8'h5a));
	emit(1, r_word(fn_sub, 2'd3, 2'd2, 2'd2));
	emit(1, r_word(fn_add, 2'd1, 2'd2, 2'd0));
	emit(1, r_word(fn_wwd, 2'd0, 2'd0, 2'd0));
	emit(1, r_word(fn_hlt, 2'd0, 2'd0, 2'd0));
	a = sext8(imm[0]) + sext8(imm[1]) + sext8(imm[2]);
	b = 16'h0000 | sext8(8'h85);
	c = {8'h5a, 8'h00};
	exp_out[1] = a + (b - c);
	exp_num[1] = prog_len[1];

	// load used by the very next instruction
	test_name[2] = "load_use";
	load_program(2, 1'b0);
	a = {8'h3c, 8'h00} | sext8(8'h55);
	exp_out[2] = a + a;
	exp_num[2] = prog_len[2];

	test_name[3] = "load_spaced";
	load_program(3, 1'b1);
	exp_out[3] = a + a;
	exp_num[3] = prog_len[3];

	// last two words sit behind hlt
	test_name[4] = "wwd_then_halt";
	emit(4, i_word(op_adi, 2'd0, 2'd1, 8'd7));
	emit(4, r_word(fn_wwd, 2'd1, 2'd0, 2'd0));
	emit(4, i_word(op_adi, 2'd1, 2'd1, 8'd1));
	emit(4, r_word(fn_wwd, 2'd1, 2'd0, 2'd0));
	emit(4, i_word(op_adi, 2'd1, 2'd1, 8'd1));
	emit(4, r_word(fn_wwd, 2'd1, 2'd0, 2'd0));
	emit(4, r_word(fn_hlt, 2'd0, 2'd0, 2'd0));
	exp_num[4] = prog_len[4];
	emit(4, i_word(op_adi, 2'd1, 2'd1, 8'd1));
	emit(4, r_word(fn_wwd, 2'd1, 2'd0, 2'd0));
	exp_out[4] = 16'd7 + 16'd1 + 16'd1;

	// r1 must start from zero again
	test_name[5] = "reset_rerun";
	emit(5, i_word(op_adi, 2'd1, 2'd1, 8'h21));
	emit(5, r_word(fn_add, 2'd1, 2'd1, 2'd2));
	emit(5, r_word(fn_wwd, 2'd2, 2'd0, 2'd0));
	emit(5, r_word(fn_hlt, 2'd0, 2'd0, 2'd0));
	a = 16'd0 + sext8(8'h21);
	exp_out[5] = a + a;
	exp_num[5] = prog_len[5];
endtask

`endif

// ==== tests/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;
	import cpu_pkg::*;

	logic                 Clk;
	logic                 rst;
	logic                 read_inst;
	logic [word_size-1:0] inst_addr;
	logic [word_size-1:0] inst_data;
	logic [word_size-1:0] num_inst;
	logic [word_size-1:0] output_port;
	logic                 is_halted;

	logic [15:0] imem [16];
	int          cur_len = 0;
	int          cycles = 0;
	int          cycle_limit = 0;
	int          error_count = 0;
	int          pass_count = 0;
	int          fail_count = 0;

	function automatic logic [15:0] xorshift16(input logic [15:0] x);
		logic [15:0] y;
		y = x ^ (x << 7);
		y = y ^ (y >> 9);
		y = y ^ (y << 8);
		return y;
	endfunction

	`include "tb_programs.svh"

	cpu_top #(
		.data_depth(256)
	) DUT (
		.Clk        (Clk),
		.rst        (rst),
		.read_inst  (read_inst),
		.inst_addr  (inst_addr),
		.inst_data  (inst_data),
		.num_inst   (num_inst),
		.output_port(output_port),
		.is_halted  (is_halted)
	);

	initial begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	// instruction memory returns hlt past the program end
	always @(negedge Clk) begin
		if (int'(inst_addr) < cur_len)
			inst_data = imem[inst_addr[3:0]];
		else
			inst_data = r_word(fn_hlt, 2'd0, 2'd0, 2'd0);
	end

	always @(posedge Clk) begin
		if (!rst)
			cycles <= cycles + 1;
	end

	initial begin
		wait (cycle_limit > 0);
		while (cycles < cycle_limit)
			@(posedge Clk);
		$display("ERROR: program did not halt within %0d cycles", cycle_limit);
		$display("Simulation FAILED");
		$finish;
	end

	task automatic check_value(input string test, input string what,
			input logic [15:0] expected, input logic [15:0] actual);
		if (actual !== expected) begin
			$display("ERR %s %s: expected 0x%04h, actual 0x%04h",
				test, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic run_test(input int t);
		int i;
		int errors_before;

		@(negedge Clk);
		rst = 1'b1;
		for (i = 0; i < 16; i++)
			imem[i] = programs[t][i];
		cur_len = prog_len[t];
		repeat (16) @(negedge Clk);
		rst = 1'b0;
		errors_before = error_count;

		// reset values hold until the next rising edge
		check_value(test_name[t], "num_inst after reset", '0, num_inst);
		check_value(test_name[t], "output_port after reset", '0, output_port);
		check_value(test_name[t], "is_halted after reset", '0, {15'd0, is_halted});
		check_value(test_name[t], "read_inst after reset", '0, {15'd0, read_inst});
		check_value(test_name[t], "inst_addr after reset", '0, inst_addr);

		while (!is_halted)
			@(negedge Clk);
		// nothing behind hlt may retire
		repeat (4) @(negedge Clk);

		check_value(test_name[t], "output_port", exp_out[t], output_port);
		check_value(test_name[t], "num_inst", 16'(exp_num[t]), num_inst);
		// fetch stopped with the pc just past the hlt word
		check_value(test_name[t], "read_inst after halt", '0, {15'd0, read_inst});
		check_value(test_name[t], "inst_addr after halt", 16'(exp_num[t]), inst_addr);

		if (error_count == errors_before) begin
			pass_count++;
			$display("test %s: ok, output 0x%04h, %0d retired",
				test_name[t], output_port, num_inst);
		end else begin
			fail_count++;
			$display("test %s: failed with %0d mismatches",
				test_name[t], error_count - errors_before);
		end
	endtask

	initial begin
		int t;
		int limit;

		rst = 1'b1;
		inst_data = '0;
		limit = 0;
		build_table();
		for (t = 0; t < num_tests; t++)
			limit += 4 * prog_len[t] + 20;
		cycle_limit = limit;

		for (t = 0; t < num_tests; t++)
			run_test(t);

		$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
